// ==== logic/fu_consts.svh ====
`ifndef FU_CONSTS_SVH
`define FU_CONSTS_SVH

// datapath width
`define XLEN 64

// rob index bits, the wrap bit sits on top of these
`define ROB_IDX_W 5

// physical register tag
`define PRF_IDX_W 6

// one bit per unresolved branch
`define BR_MASK_W 4

// multiplier depth, each stage takes XLEN/MULT_STAGES multiplier bits
`define MULT_STAGES 4

// hardwired zero register
`define ZERO_REG 0

`endif

// ==== logic/isa_pkg.sv ====
`include "fu_consts.svh"

package isa_pkg;

	typedef logic [`XLEN-1:0] xlen_t;
	typedef logic [`PRF_IDX_W-1:0] prf_tag_t;
	// msb is the wrap bit
	typedef logic [`ROB_IDX_W:0] rob_idx_t;
	typedef logic [`BR_MASK_W-1:0] br_mask_t;
	// displacement in instruction words
	typedef logic signed [20:0] br_disp_t;

	typedef enum logic [1:0] {
		FU_NONE,
		FU_ALU,
		FU_BR,
		FU_MULT
	} fu_sel_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_CMPEQ,
		ALU_CMPLT
	} alu_op_e;

	// conditions test ra only
	typedef enum logic [2:0] {
		BR_ALWAYS,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE
	} br_op_e;

endpackage

// ==== logic/fu_pkg.sv ====
package fu_pkg;

	typedef struct packed {
		isa_pkg::fu_sel_e sel;
		isa_pkg::alu_op_e alu_op;
		isa_pkg::br_op_e br_op;
		isa_pkg::xlen_t opa;
		isa_pkg::xlen_t opb;
		isa_pkg::xlen_t npc;
		isa_pkg::br_disp_t disp;
		isa_pkg::prf_tag_t dest_tag;
		isa_pkg::rob_idx_t rob_idx;
		isa_pkg::br_mask_t br_mask;
	} iss_pkt_t;

	typedef struct packed {
		logic vld;
		isa_pkg::xlen_t value;
		isa_pkg::prf_tag_t dest_tag;
		isa_pkg::rob_idx_t rob_idx;
		isa_pkg::br_mask_t br_mask;
	} ex_res_t;

	typedef struct packed {
		logic vld;
		logic taken;
		isa_pkg::xlen_t target;
		isa_pkg::rob_idx_t rob_idx;
	} br_res_t;

	// tag_fix is one-hot
	typedef struct packed {
		logic recovery;
		logic pred_correct;
		isa_pkg::br_mask_t tag_fix;
	} br_evt_t;

	typedef struct packed {
		logic vld;
		isa_pkg::prf_tag_t tag;
		isa_pkg::xlen_t value;
	} cdb_t;

	typedef struct packed {
		logic vld;
		isa_pkg::rob_idx_t rob_idx;
	} rob_done_t;

	// op depends on the branch being recovered
	function automatic logic br_hit(isa_pkg::br_mask_t mask, br_evt_t evt);
		return evt.recovery && ((mask & evt.tag_fix) != '0);
	endfunction

	function automatic isa_pkg::br_mask_t br_clear(isa_pkg::br_mask_t mask, br_evt_t evt);
		return evt.pred_correct ? (mask & ~evt.tag_fix) : mask;
	endfunction

	function automatic ex_res_t ex_filter(ex_res_t res, br_evt_t evt);
		ex_res_t r;
		r = res;
		r.vld = res.vld & ~br_hit(res.br_mask, evt);
		r.br_mask = br_clear(res.br_mask, evt);
		return r;
	endfunction

endpackage

// ==== logic/fu_alu.sv ====
`timescale 1ns/1ps
`include "fu_consts.svh"

module fu_alu (
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  fu_pkg::iss_pkt_t pkt_i,
	input  fu_pkg::br_evt_t br_evt_i,
	output fu_pkg::ex_res_t res_o
);

	localparam int SHAMT_W = $clog2(`XLEN);

	isa_pkg::xlen_t value;
	logic [SHAMT_W-1:0] shamt;
	fu_pkg::ex_res_t res_nxt;
	fu_pkg::ex_res_t res_r;

	assign shamt = pkt_i.opb[SHAMT_W-1:0];

	always_comb begin
		case (pkt_i.alu_op)
			isa_pkg::ALU_ADD:   value = pkt_i.opa + pkt_i.opb;
			isa_pkg::ALU_SUB:   value = pkt_i.opa - pkt_i.opb;
			isa_pkg::ALU_AND:   value = pkt_i.opa & pkt_i.opb;
			isa_pkg::ALU_OR:    value = pkt_i.opa | pkt_i.opb;
			isa_pkg::ALU_XOR:   value = pkt_i.opa ^ pkt_i.opb;
			isa_pkg::ALU_SLL:   value = pkt_i.opa << shamt;
			isa_pkg::ALU_SRL:   value = pkt_i.opa >> shamt;
			isa_pkg::ALU_CMPEQ: value = isa_pkg::xlen_t'(pkt_i.opa == pkt_i.opb);
			// signed compare
			isa_pkg::ALU_CMPLT: value = isa_pkg::xlen_t'($signed(pkt_i.opa) < $signed(pkt_i.opb));
			default:            value = '0;
		endcase
	end

	assign res_nxt = '{
		vld: start_i,
		value: value,
		dest_tag: pkt_i.dest_tag,
		rob_idx: pkt_i.rob_idx,
		br_mask: pkt_i.br_mask
	};

	always_ff @(posedge clk) begin
		res_r <= fu_pkg::ex_filter(res_nxt, br_evt_i);
		if (rst) begin
			res_r.vld <= 1'b0;
		end
	end

	// held result also sees this cycle's event
	assign res_o = fu_pkg::ex_filter(res_r, br_evt_i);

	// unit select decode in the top must match the packet
	a_start_sel: assert property (@(posedge clk) disable iff (rst)
		start_i |-> pkt_i.sel == isa_pkg::FU_ALU);

endmodule

// ==== logic/fu_br.sv ====
`timescale 1ns/1ps

module fu_br (
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  fu_pkg::iss_pkt_t pkt_i,
	input  fu_pkg::br_evt_t br_evt_i,
	output fu_pkg::br_res_t res_o
);

	localparam int MSB = $bits(isa_pkg::xlen_t) - 1;

	logic taken;
	isa_pkg::xlen_t disp_ext;
	fu_pkg::br_res_t res_nxt;
	fu_pkg::br_res_t res_r;
	isa_pkg::br_mask_t mask_r;

	always_comb begin
		case (pkt_i.br_op)
			isa_pkg::BR_ALWAYS: taken = 1'b1;
			isa_pkg::BR_BEQ:    taken = pkt_i.opa == '0;
			isa_pkg::BR_BNE:    taken = pkt_i.opa != '0;
			isa_pkg::BR_BLT:    taken = pkt_i.opa[MSB];
			isa_pkg::BR_BGE:    taken = ~pkt_i.opa[MSB];
			default:            taken = 1'b0;
		endcase
	end

	// word displacement, sign extended then scaled to bytes
	assign disp_ext = isa_pkg::xlen_t'(signed'(pkt_i.disp));

	assign res_nxt.vld = start_i & ~fu_pkg::br_hit(pkt_i.br_mask, br_evt_i);
	assign res_nxt.taken = taken;
	assign res_nxt.target = taken ? pkt_i.npc + (disp_ext << 2) : pkt_i.npc;
	assign res_nxt.rob_idx = pkt_i.rob_idx;

	always_ff @(posedge clk) begin
		res_r <= res_nxt;
		mask_r <= fu_pkg::br_clear(pkt_i.br_mask, br_evt_i);
		if (rst) begin
			res_r.vld <= 1'b0;
		end
	end

	always_comb begin
		res_o = res_r;
		res_o.vld = res_r.vld & ~fu_pkg::br_hit(mask_r, br_evt_i);
	end

endmodule

// ==== logic/fu_mult.sv ====
`timescale 1ns/1ps
`include "fu_consts.svh"

module fu_mult (
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  fu_pkg::iss_pkt_t pkt_i,
	input  fu_pkg::br_evt_t br_evt_i,
	output logic done_pre_o,
	output fu_pkg::ex_res_t res_o
);

	localparam int QW = `XLEN / `MULT_STAGES;
	localparam int LAST = `MULT_STAGES - 1;

	typedef struct packed {
		logic vld;
		isa_pkg::xlen_t prod;
		isa_pkg::xlen_t opa;
		isa_pkg::xlen_t opb;
		isa_pkg::prf_tag_t dest_tag;
		isa_pkg::rob_idx_t rob_idx;
		isa_pkg::br_mask_t br_mask;
	} stage_t;

	stage_t stage_in [`MULT_STAGES];
	stage_t stage_r [`MULT_STAGES];
	fu_pkg::ex_res_t last_res;

	assign stage_in[0] = '{
		vld: start_i,
		prod: '0,
		opa: pkt_i.opa,
		opb: pkt_i.opb,
		dest_tag: pkt_i.dest_tag,
		rob_idx: pkt_i.rob_idx,
		br_mask: pkt_i.br_mask
	};

	for (genvar s = 1; s < `MULT_STAGES; s++) begin : g_link
		assign stage_in[s] = stage_r[s-1];
	end

	for (genvar s = 0; s < `MULT_STAGES; s++) begin : g_stage
		isa_pkg::xlen_t part;
		stage_t nxt;

		// one slice of multiplier bits, only the low product word is kept
		assign part = stage_in[s].opa * isa_pkg::xlen_t'(stage_in[s].opb[s*QW +: QW]);

		always_comb begin
			nxt = stage_in[s];
			nxt.vld = stage_in[s].vld & ~fu_pkg::br_hit(stage_in[s].br_mask, br_evt_i);
			nxt.br_mask = fu_pkg::br_clear(stage_in[s].br_mask, br_evt_i);
			nxt.prod = stage_in[s].prod + (part << (s * QW));
		end

		always_ff @(posedge clk) begin
			stage_r[s] <= nxt;
			if (rst) begin
				stage_r[s].vld <= 1'b0;
			end
		end
	end

	// last stage finishes next cycle
	assign done_pre_o = stage_r[`MULT_STAGES-2].vld;

	assign last_res = '{
		vld: stage_r[LAST].vld,
		value: stage_r[LAST].prod,
		dest_tag: stage_r[LAST].dest_tag,
		rob_idx: stage_r[LAST].rob_idx,
		br_mask: stage_r[LAST].br_mask
	};

	assign res_o = fu_pkg::ex_filter(last_res, br_evt_i);

endmodule

// ==== logic/fu_wb.sv ====
`timescale 1ns/1ps
`include "fu_consts.svh"

module fu_wb (
	input  logic clk,
	input  logic rst,
	input  fu_pkg::ex_res_t alu_i,
	input  fu_pkg::ex_res_t mult_i,
	input  fu_pkg::br_res_t br_i,
	input  fu_pkg::br_evt_t br_evt_i,
	output fu_pkg::cdb_t cdb_o,
	output fu_pkg::rob_done_t rob_done_o
);

	fu_pkg::cdb_t cdb_nxt;
	fu_pkg::cdb_t cdb_r;
	fu_pkg::rob_done_t done_nxt;
	fu_pkg::rob_done_t done_r;
	isa_pkg::br_mask_t mask_nxt;
	isa_pkg::br_mask_t mask_r;
	logic kill;

	always_comb begin
		cdb_nxt.vld = 1'b0;
		cdb_nxt.tag = isa_pkg::prf_tag_t'(`ZERO_REG);
		cdb_nxt.value = '0;
		done_nxt.vld = 1'b0;
		done_nxt.rob_idx = '0;
		mask_nxt = '0;
		if (alu_i.vld) begin
			cdb_nxt = '{vld: 1'b1, tag: alu_i.dest_tag, value: alu_i.value};
			done_nxt = '{vld: 1'b1, rob_idx: alu_i.rob_idx};
			mask_nxt = alu_i.br_mask;
		end else if (mult_i.vld) begin
			cdb_nxt = '{vld: 1'b1, tag: mult_i.dest_tag, value: mult_i.value};
			done_nxt = '{vld: 1'b1, rob_idx: mult_i.rob_idx};
			mask_nxt = mult_i.br_mask;
		end else if (br_i.vld) begin
			// branch has no destination, completion only
			done_nxt = '{vld: 1'b1, rob_idx: br_i.rob_idx};
		end
	end

	always_ff @(posedge clk) begin
		cdb_r <= cdb_nxt;
		done_r <= done_nxt;
		mask_r <= mask_nxt;
		if (rst) begin
			cdb_r.vld <= 1'b0;
			done_r.vld <= 1'b0;
		end
	end

	assign kill = fu_pkg::br_hit(mask_r, br_evt_i);

	always_comb begin
		cdb_o = cdb_r;
		cdb_o.vld = cdb_r.vld & ~kill;
		rob_done_o = done_r;
		rob_done_o.vld = done_r.vld & ~kill;
	end

	// the issue stall keeps the units off the single port
	a_one_src: assert property (@(posedge clk) disable iff (rst)
		$onehot0({alu_i.vld, mult_i.vld, br_i.vld}));

endmodule

// ==== logic/fu_main.sv ====
`timescale 1ns/1ps

module fu_main (
	input  logic clk,
	input  logic rst,
	input  logic iss_vld_i,
	input  fu_pkg::iss_pkt_t iss_pkt_i,
	input  fu_pkg::br_evt_t br_evt_i,
	output logic iss_stall_o,
	output fu_pkg::cdb_t cdb_o,
	output fu_pkg::rob_done_t rob_done_o,
	output fu_pkg::br_res_t br_res_o
);

	logic accept;
	logic alu_start;
	logic br_start;
	logic mult_start;
	logic mult_done_pre;
	fu_pkg::ex_res_t alu_res;
	fu_pkg::ex_res_t mult_res;

	// hold issue while a product heads for writeback
	assign iss_stall_o = mult_done_pre;
	assign accept = iss_vld_i & ~iss_stall_o;

	always_comb begin
		alu_start = 1'b0;
		br_start = 1'b0;
		mult_start = 1'b0;
		case (iss_pkt_i.sel)
			isa_pkg::FU_ALU:  alu_start = accept;
			isa_pkg::FU_BR:   br_start = accept;
			isa_pkg::FU_MULT: mult_start = accept;
			default: ;
		endcase
	end

	fu_alu u_alu (
		.clk      (clk),
		.rst      (rst),
		.start_i  (alu_start),
		.pkt_i    (iss_pkt_i),
		.br_evt_i (br_evt_i),
		.res_o    (alu_res)
	);

	fu_br u_br (
		.clk      (clk),
		.rst      (rst),
		.start_i  (br_start),
		.pkt_i    (iss_pkt_i),
		.br_evt_i (br_evt_i),
		.res_o    (br_res_o)
	);

	fu_mult u_mult (
		.clk        (clk),
		.rst        (rst),
		.start_i    (mult_start),
		.pkt_i      (iss_pkt_i),
		.br_evt_i   (br_evt_i),
		.done_pre_o (mult_done_pre),
		.res_o      (mult_res)
	);

	fu_wb u_wb (
		.clk        (clk),
		.rst        (rst),
		.alu_i      (alu_res),
		.mult_i     (mult_res),
		.br_i       (br_res_o),
		.br_evt_i   (br_evt_i),
		.cdb_o      (cdb_o),
		.rob_done_o (rob_done_o)
	);

endmodule

// ==== test/fu_main_tb.sv ====
`timescale 1ns/1ps
`include "fu_consts.svh"

module fu_main_tb;

	localparam int MULT_LAT = `MULT_STAGES + 1;
	localparam int WAIT_MAX = 40;

	logic clk;
	logic rst;
	logic iss_vld_i;
	fu_pkg::iss_pkt_t iss_pkt_i;
	fu_pkg::br_evt_t br_evt_i;
	logic iss_stall_o;
	fu_pkg::cdb_t cdb_o;
	fu_pkg::rob_done_t rob_done_o;
	fu_pkg::br_res_t br_res_o;

	int cyc_cnt = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	logic [31:0] lfsr;
	logic [7:0] seq;

	// expected results with the cycle count at which each must show
	fu_pkg::cdb_t exp_cdb[$];
	int exp_cdb_at[$];
	fu_pkg::rob_done_t exp_done[$];
	int exp_done_at[$];
	fu_pkg::br_res_t exp_br[$];
	int exp_br_at[$];

	fu_main UUT (
		.clk         (clk),
		.rst         (rst),
		.iss_vld_i   (iss_vld_i),
		.iss_pkt_i   (iss_pkt_i),
		.br_evt_i    (br_evt_i),
		.iss_stall_o (iss_stall_o),
		.cdb_o       (cdb_o),
		.rob_done_o  (rob_done_o),
		.br_res_o    (br_res_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
	end

	// fibonacci lfsr on taps 32 22 2 1 stepped once per bit
	function automatic isa_pkg::xlen_t rand_bits(int n);
		isa_pkg::xlen_t r;
		logic fb;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[`XLEN-2:0], fb};
		end
		return r;
	endfunction

	function automatic fu_pkg::iss_pkt_t base_pkt(isa_pkg::fu_sel_e sel, isa_pkg::br_mask_t mask);
		fu_pkg::iss_pkt_t p;
		p.sel = sel;
		p.alu_op = isa_pkg::ALU_ADD;
		p.br_op = isa_pkg::BR_ALWAYS;
		p.opa = rand_bits(64);
		p.opb = rand_bits(64);
		p.npc = rand_bits(62) << 2;
		p.disp = isa_pkg::br_disp_t'(rand_bits(21));
		// tag never equals the rob index
		p.dest_tag = seq[5:0] ^ 6'h2a;
		p.rob_idx = seq[5:0];
		p.br_mask = mask;
		seq = seq + 8'd1;
		return p;
	endfunction

	function automatic isa_pkg::xlen_t alu_model(fu_pkg::iss_pkt_t p);
		case (p.alu_op)
			isa_pkg::ALU_ADD:   return p.opa + p.opb;
			isa_pkg::ALU_SUB:   return p.opa + ~p.opb + 64'd1;
			isa_pkg::ALU_AND:   return p.opa & p.opb;
			isa_pkg::ALU_OR:    return p.opa | p.opb;
			isa_pkg::ALU_XOR:   return p.opa ^ p.opb;
			isa_pkg::ALU_SLL:   return p.opa << p.opb[5:0];
			isa_pkg::ALU_SRL:   return p.opa >> p.opb[5:0];
			isa_pkg::ALU_CMPEQ: return (p.opa == p.opb) ? 64'd1 : 64'd0;
			default: begin
				// with differing signs the negative operand is smaller
				if (p.opa[`XLEN-1] != p.opb[`XLEN-1]) begin
					return {63'd0, p.opa[`XLEN-1]};
				end
				return (p.opa < p.opb) ? 64'd1 : 64'd0;
			end
		endcase
	endfunction

	function automatic fu_pkg::br_res_t br_model(fu_pkg::iss_pkt_t p);
		fu_pkg::br_res_t r;
		logic neg;
		logic zero;
		neg = p.opa[`XLEN-1];
		zero = (p.opa == 64'd0);
		case (p.br_op)
			isa_pkg::BR_BEQ: r.taken = zero;
			isa_pkg::BR_BNE: r.taken = !zero;
			isa_pkg::BR_BLT: r.taken = neg;
			isa_pkg::BR_BGE: r.taken = !neg;
			default:         r.taken = 1'b1;
		endcase
		r.vld = 1'b1;
		r.rob_idx = p.rob_idx;
		r.target = r.taken ? p.npc + isa_pkg::xlen_t'(longint'(p.disp) * 4) : p.npc;
		return r;
	endfunction

	task automatic check_cdb(fu_pkg::cdb_t exp, fu_pkg::cdb_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail at %0t: cdb_o expected %h, got %h", $time, exp, act);
		end
	endtask

	task automatic check_rob_done(fu_pkg::rob_done_t exp, fu_pkg::rob_done_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail at %0t: rob_done_o expected %h, got %h", $time, exp, act);
		end
	endtask

	task automatic check_br(fu_pkg::br_res_t exp, fu_pkg::br_res_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail at %0t: br_res_o expected %h, got %h", $time, exp, act);
		end
	endtask

	task automatic check_stall(logic exp, logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail at %0t: iss_stall_o expected %b, got %b", $time, exp, act);
		end
	endtask

	task automatic unexpected(string name);
		errors++;
		$display("%s went valid at %0t with no result due", name, $time);
	endtask

	// compare whatever is due at the next falling edge
	task automatic step();
		@(negedge clk);
		if (exp_cdb_at.size() > 0 && exp_cdb_at[0] <= cyc_cnt) begin
			void'(exp_cdb_at.pop_front());
			check_cdb(exp_cdb.pop_front(), cdb_o);
		end else if (cdb_o.vld) begin
			unexpected("cdb_o");
		end
		if (exp_done_at.size() > 0 && exp_done_at[0] <= cyc_cnt) begin
			void'(exp_done_at.pop_front());
			check_rob_done(exp_done.pop_front(), rob_done_o);
		end else if (rob_done_o.vld) begin
			unexpected("rob_done_o");
		end
		if (exp_br_at.size() > 0 && exp_br_at[0] <= cyc_cnt) begin
			void'(exp_br_at.pop_front());
			check_br(exp_br.pop_front(), br_res_o);
		end else if (br_res_o.vld) begin
			unexpected("br_res_o");
		end
	endtask

	function automatic int slot(int q[$], int at);
		int i;
		i = 0;
		while (i < q.size() && q[i] <= at) begin
			i++;
		end
		return i;
	endfunction

	// op goes in at the coming rising edge
	task automatic expect_results(fu_pkg::iss_pkt_t p);
		fu_pkg::cdb_t c;
		fu_pkg::rob_done_t d;
		int lat;
		int i;
		lat = (p.sel == isa_pkg::FU_MULT) ? MULT_LAT : 2;
		d.vld = 1'b1;
		d.rob_idx = p.rob_idx;
		i = slot(exp_done_at, cyc_cnt + lat);
		exp_done.insert(i, d);
		exp_done_at.insert(i, cyc_cnt + lat);
		if (p.sel == isa_pkg::FU_BR) begin
			exp_br.push_back(br_model(p));
			exp_br_at.push_back(cyc_cnt + 1);
		end else begin
			c.vld = 1'b1;
			c.tag = p.dest_tag;
			c.value = (p.sel == isa_pkg::FU_MULT) ? p.opa * p.opb : alu_model(p);
			i = slot(exp_cdb_at, cyc_cnt + lat);
			exp_cdb.insert(i, c);
			exp_cdb_at.insert(i, cyc_cnt + lat);
		end
	endtask

	// holds the op while stalled
	task automatic issue(fu_pkg::iss_pkt_t p, bit completes);
		int t;
		iss_vld_i = 1'b1;
		iss_pkt_i = p;
		for (t = 0; t < WAIT_MAX && iss_stall_o; t++) begin
			step();
		end
		if (iss_stall_o) begin
			errors++;
			$display("issue stall did not drop within %0d cycles", WAIT_MAX);
		end else if (completes) begin
			expect_results(p);
		end
		step();
		iss_vld_i = 1'b0;
	endtask

	task automatic drain();
		int t;
		for (t = 0; t < WAIT_MAX && exp_done.size() + exp_cdb.size() + exp_br.size() > 0; t++) begin
			step();
		end
		if (exp_done.size() + exp_cdb.size() + exp_br.size() > 0) begin
			errors++;
			$display("results still outstanding after %0d cycles", WAIT_MAX);
			exp_cdb.delete();
			exp_cdb_at.delete();
			exp_done.delete();
			exp_done_at.delete();
			exp_br.delete();
			exp_br_at.delete();
		end
		// quiet tail catches late strays
		repeat (3) step();
	endtask

	task automatic report(string name, int err0);
		tests++;
		if (errors == err0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - err0);
		end
	endtask

	task automatic test_idle();
		int err0;
		err0 = errors;
		repeat (4) begin
			step();
			check_stall(1'b0, iss_stall_o);
		end
		report("idle after reset", err0);
	endtask

	task automatic test_alu();
		int err0;
		int i;
		fu_pkg::iss_pkt_t p;
		err0 = errors;
		for (i = 0; i < 10; i++) begin
			p = base_pkt(isa_pkg::FU_ALU, '0);
			p.alu_op = isa_pkg::alu_op_e'((i < 9) ? i : 7);
			// one compare of equal operands
			if (i == 9) begin
				p.opb = p.opa;
			end
			issue(p, 1'b1);
		end
		drain();
		report("alu ops", err0);
	endtask

	task automatic test_branch();
		int err0;
		int i;
		int k;
		fu_pkg::iss_pkt_t p;
		err0 = errors;
		for (i = 0; i < 5; i++) begin
			for (k = 0; k < 3; k++) begin
				p = base_pkt(isa_pkg::FU_BR, '0);
				p.br_op = isa_pkg::br_op_e'(i);
				if (k == 0) begin
					p.opa = '0;
				end else if (k == 1) begin
					p.opa = rand_bits(63) | 64'd1;
				end else begin
					p.opa = rand_bits(63) | {1'b1, 63'd0};
				end
				issue(p, 1'b1);
			end
		end
		drain();
		report("branch resolve", err0);
	endtask

	task automatic test_mult();
		int err0;
		int i;
		fu_pkg::iss_pkt_t p;
		err0 = errors;
		for (i = 0; i < 4; i++) begin
			p = base_pkt(isa_pkg::FU_MULT, '0);
			issue(p, 1'b1);
		end
		drain();
		p = base_pkt(isa_pkg::FU_MULT, '0);
		issue(p, 1'b1);
		step();
		step();
		check_stall(1'b1, iss_stall_o);
		p = base_pkt(isa_pkg::FU_ALU, '0);
		p.alu_op = isa_pkg::ALU_XOR;
		issue(p, 1'b1);
		drain();
		report("pipelined multiply", err0);
	endtask

	task automatic test_recovery();
		int err0;
		fu_pkg::iss_pkt_t p;
		err0 = errors;
		p = base_pkt(isa_pkg::FU_MULT, 4'b0010);
		issue(p, 1'b0);
		p = base_pkt(isa_pkg::FU_MULT, 4'b0100);
		issue(p, 1'b1);
		p = base_pkt(isa_pkg::FU_ALU, 4'b0010);
		issue(p, 1'b0);
		br_evt_i = '{recovery: 1'b1, pred_correct: 1'b0, tag_fix: 4'b0010};
		step();
		br_evt_i = '0;
		drain();
		report("branch recovery", err0);
	endtask

	task automatic test_pred_correct();
		int err0;
		fu_pkg::iss_pkt_t p;
		err0 = errors;
		p = base_pkt(isa_pkg::FU_MULT, 4'b0100);
		issue(p, 1'b1);
		// the alu op is filtered on its way in
		br_evt_i = '{recovery: 1'b0, pred_correct: 1'b1, tag_fix: 4'b0100};
		p = base_pkt(isa_pkg::FU_ALU, 4'b0100);
		p.alu_op = isa_pkg::ALU_SUB;
		issue(p, 1'b1);
		br_evt_i = '{recovery: 1'b1, pred_correct: 1'b0, tag_fix: 4'b0100};
		step();
		br_evt_i = '0;
		drain();
		report("correct prediction", err0);
	endtask

	initial begin
		rst = 1'b1;
		iss_vld_i = 1'b0;
		iss_pkt_i = '0;
		br_evt_i = '0;
		lfsr = 32'hd72e849e;
		seq = 8'd1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_idle();
		test_alu();
		test_branch();
		test_mult();
		test_recovery();
		test_pred_correct();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+logic
logic/isa_pkg.sv
logic/fu_pkg.sv
logic/fu_alu.sv
logic/fu_br.sv
logic/fu_mult.sv
logic/fu_wb.sv
logic/fu_main.sv
test/fu_main_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module fu_main_tb -Mdir obj_dir -f build.f
./obj_dir/Vfu_main_tb | tee sim.log

if grep -qx "Simulation passed" sim.log; then
	exit 0
fi
exit 1
